// ==== cache_pkg.sv ====
`default_nettype none

package cache_pkg;

        // physical fetch address
        localparam int addr_width = 32;

        // byte offset inside a 16-byte line
        localparam int offset_width = 4;

        // four words per line
        localparam int line_words = 4;

        // word slot inside a line
        localparam int word_sel_width = 2;

        typedef logic [31:0] word_t;

        // fetch request from the cpu side
        typedef struct packed {
                logic [addr_width-1:0]  addr;
                logic                   cacheable;
        } cpu_req_t;

        // controller states
        typedef enum logic [1:0] {
                idle    = 2'd0,
                lookup  = 2'd1,
                miss    = 2'd2,
                refill  = 2'd3
        } icache_state_e;

endpackage

`default_nettype wire

// ==== axi_pkg.sv ====
`default_nettype none

package axi_pkg;

        typedef enum logic [1:0] {
                burst_fixed     = 2'd0,
                burst_incr      = 2'd1,
                burst_wrap      = 2'd2
        } axi_burst_e;

        // bytes per beat, log2 encoded
        typedef enum logic [2:0] {
                size_byte       = 3'd0,
                size_half       = 3'd1,
                size_word       = 3'd2
        } axi_size_e;

        // read address channel
        typedef struct packed {
                logic [3:0]     id;
                logic [31:0]    addr;
                logic [7:0]     len;
                axi_size_e      size;
                axi_burst_e     burst;
        } axi_ar_t;

        // read data channel
        typedef struct packed {
                logic [3:0]     id;
                logic [31:0]    data;
                logic [1:0]     resp;
                logic           last;
        } axi_r_t;

        // only one read stream, so a single id
        localparam logic [3:0] ar_id = 4'd0;

endpackage

`default_nettype wire

// ==== refill_counter.sv ====
`default_nettype none

module refill_counter (
        input  logic                                    clk,
        input  logic                                    reset,
        input  logic                                    start,
        input  logic                                    beat,
        output logic [cache_pkg::word_sel_width-1:0]    slot
);
        import cache_pkg::*;

        // burst order, word 0 of the line first
        always_ff @(posedge clk) begin
                if (reset) begin
                        slot <= '0;
                end else if (start) begin
                        slot <= '0;
                end else if (beat) begin
                        slot <= slot + word_sel_width'(1);
                end
        end

endmodule

`default_nettype wire

// ==== tag_array.sv ====
`default_nettype none

module tag_array #(
        parameter int index_width = 8
) (
        input  logic                                    clk,
        input  logic                                    reset,
        input  logic [cache_pkg::addr_width-1:0]        lookup_addr,
        input  logic                                    fill_tag,
        output logic                                    hit
);
        import cache_pkg::*;

        localparam int tag_width = addr_width - index_width - offset_width;
        localparam int set_count = 1 << index_width;

        logic [set_count-1:0]   valid_bits;
        logic [tag_width-1:0]   tags [set_count];
        logic [index_width-1:0] set_idx;
        logic [index_width-1:0] set_q;
        logic [tag_width-1:0]   tag_in;
        logic [tag_width-1:0]   tag_q;

        assign set_idx = lookup_addr[offset_width +: index_width];
        assign tag_in = lookup_addr[addr_width-1 -: tag_width];

        always_ff @(posedge clk) begin
                if (reset) begin
                        valid_bits <= '0;
                end else if (fill_tag) begin
                        valid_bits[set_idx] <= 1'b1;
                end
        end

        always_ff @(posedge clk) begin
                if (fill_tag) begin
                        tags[set_idx] <= tag_in;
                end
                set_q <= set_idx;
                tag_q <= tag_in;
        end

        // compare in the cycle after the address was presented
        assign hit = valid_bits[set_q] && (tags[set_q] == tag_q);

endmodule

`default_nettype wire

// ==== data_array.sv ====
`default_nettype none

module data_array #(
        parameter int index_width = 8
) (
        input  logic                                    clk,
        input  logic [cache_pkg::addr_width-1:0]        lookup_addr,
        input  logic                                    fill,
        input  logic [cache_pkg::word_sel_width-1:0]    slot,
        input  cache_pkg::word_t                        fill_data,
        output cache_pkg::word_t                        word
);
        import cache_pkg::*;

        localparam int set_count = 1 << index_width;

        word_t                          mem [set_count][line_words];
        logic [index_width-1:0]         set_idx;
        logic [word_sel_width-1:0]      word_idx;

        assign set_idx = lookup_addr[offset_width +: index_width];
        assign word_idx = lookup_addr[offset_width-1 -: word_sel_width];

        always_ff @(posedge clk) begin
                if (fill) begin
                        mem[set_idx][slot] <= fill_data;
                end
        end

        // last refill beat may carry the very word being read
        always_ff @(posedge clk) begin
                if (fill && (slot == word_idx)) begin
                        word <= fill_data;
                end else begin
                        word <= mem[set_idx][word_idx];
                end
        end

endmodule

`default_nettype wire

// ==== icache_ctrl.sv ====
`default_nettype none

module icache_ctrl (
        input  logic                                    clk,
        input  logic                                    reset,
        input  logic                                    valid,
        input  cache_pkg::cpu_req_t                     req,
        input  logic                                    hit,
        input  cache_pkg::word_t                        word,
        input  logic                                    arready,
        input  axi_pkg::axi_r_t                         r,
        input  logic                                    rvalid,
        output logic                                    addr_ok,
        output logic                                    data_ok,
        output cache_pkg::word_t                        rdata,
        output logic [cache_pkg::addr_width-1:0]        lookup_addr,
        output logic                                    fill_tag,
        output logic                                    fill,
        output axi_pkg::axi_ar_t                        ar,
        output logic                                    arvalid,
        output logic                                    rready,
        output logic                                    start,
        output logic                                    beat
);
        import cache_pkg::*;
        import axi_pkg::*;

        icache_state_e  state;
        icache_state_e  state_next;
        cpu_req_t       held;
        logic           accept;
        logic           lookup_hit;
        logic           last_beat;

        // uncached requests never count as a hit
        assign lookup_hit = (state == lookup) && hit && held.cacheable;
        assign addr_ok = (state == idle) ? valid : lookup_hit;
        assign accept = valid && addr_ok;

        // arrays see the new address in the cycle it is taken
        assign lookup_addr = accept ? req.addr : held.addr;

        always_ff @(posedge clk) begin
                if (accept) begin
                        held <= req;
                end
        end

        assign arvalid = (state == miss);
        assign rready = (state == refill);
        assign start = arvalid && arready;
        assign beat = rvalid && rready;
        assign last_beat = beat && r.last;

        assign fill = beat && held.cacheable;
        assign fill_tag = fill && r.last;

        assign data_ok = lookup_hit || (last_beat && !held.cacheable);
        assign rdata = (state == refill) ? r.data : word;

        // whole line for cached misses, one word otherwise
        always_comb begin
                ar.id = ar_id;
                ar.size = size_word;
                ar.burst = burst_incr;
                if (held.cacheable) begin
                        ar.addr = {held.addr[addr_width-1:offset_width], {offset_width{1'b0}}};
                        ar.len = 8'(line_words - 1);
                end else begin
                        ar.addr = {held.addr[addr_width-1:2], 2'b00};
                        ar.len = 8'd0;
                end
        end

        always_comb begin
                state_next = state;
                case (state)
                        idle: if (accept) state_next = lookup;
                        lookup: begin
                                if (!lookup_hit) begin
                                        state_next = miss;
                                end else if (!accept) begin
                                        state_next = idle;
                                end
                        end
                        miss: if (arready) state_next = refill;
                        refill: begin
                                if (last_beat) begin
                                        state_next = held.cacheable ? lookup : idle;
                                end
                        end
                        default: state_next = idle;
                endcase
        end

        always_ff @(posedge clk) begin
                if (reset) begin
                        state <= idle;
                end else begin
                        state <= state_next;
                end
        end

endmodule

`default_nettype wire

// ==== icache_top.sv ====
`default_nettype none

module icache_top #(
        parameter int index_width = 8
) (
        input  logic                    clk,
        input  logic                    reset,
        input  logic                    valid,
        input  cache_pkg::cpu_req_t     req,
        output logic                    addr_ok,
        output logic                    data_ok,
        output cache_pkg::word_t        rdata,
        output axi_pkg::axi_ar_t        ar,
        output logic                    arvalid,
        input  logic                    arready,
        input  axi_pkg::axi_r_t         r,
        input  logic                    rvalid,
        output logic                    rready
);
        import cache_pkg::*;

        logic [addr_width-1:0]          lookup_addr;
        logic                           hit;
        logic                           fill_tag;
        logic                           fill;
        logic                           start;
        logic                           beat;
        logic [word_sel_width-1:0]      slot;
        word_t                          word;

        icache_ctrl u_ctrl (
                .clk            (clk),
                .reset          (reset),
                .valid          (valid),
                .req            (req),
                .hit            (hit),
                .word           (word),
                .arready        (arready),
                .r              (r),
                .rvalid         (rvalid),
                .addr_ok        (addr_ok),
                .data_ok        (data_ok),
                .rdata          (rdata),
                .lookup_addr    (lookup_addr),
                .fill_tag       (fill_tag),
                .fill           (fill),
                .ar             (ar),
                .arvalid        (arvalid),
                .rready         (rready),
                .start          (start),
                .beat           (beat)
        );

        refill_counter u_counter (
                .clk            (clk),
                .reset          (reset),
                .start          (start),
                .beat           (beat),
                .slot           (slot)
        );

        tag_array #(
                .index_width    (index_width)
        ) u_tags (
                .clk            (clk),
                .reset          (reset),
                .lookup_addr    (lookup_addr),
                .fill_tag       (fill_tag),
                .hit            (hit)
        );

        data_array #(
                .index_width    (index_width)
        ) u_data (
                .clk            (clk),
                .lookup_addr    (lookup_addr),
                .fill           (fill),
                .slot           (slot),
                .fill_data      (r.data),
                .word           (word)
        );

endmodule

`default_nettype wire

// ==== icache_ctrl_assert.sv ====
`default_nettype none

module icache_ctrl_assert (
        input  logic                            clk,
        input  logic                            reset,
        input  logic                            valid,
        input  logic                            addr_ok,
        input  logic                            data_ok,
        input  logic                            arvalid,
        input  logic                            arready,
        input  axi_pkg::axi_ar_t                ar,
        input  logic                            rready,
        input  logic                            rvalid,
        input  axi_pkg::axi_r_t                 r
);
        // accepted requests still waiting for data_ok
        logic [3:0]     outstanding;
        // open from the ar handshake to the last read beat
        logic           burst_open;

        always_ff @(posedge clk) begin
                if (reset) begin
                        outstanding <= '0;
                end else begin
                        outstanding <= outstanding + 4'(valid && addr_ok) - 4'(data_ok);
                end
        end

        always_ff @(posedge clk) begin
                if (reset) begin
                        burst_open <= 1'b0;
                end else if (arvalid && arready) begin
                        burst_open <= 1'b1;
                end else if (rvalid && rready && r.last) begin
                        burst_open <= 1'b0;
                end
        end

        ar_hold: assert property (@(posedge clk) disable iff (reset)
                arvalid && !arready |=> arvalid && $stable(ar))
                else $error("arvalid or ar changed before arready");

        rready_in_burst: assert property (@(posedge clk) disable iff (reset)
                rready |-> burst_open)
                else $error("rready high with no read burst open");

        data_ok_owed: assert property (@(posedge clk) disable iff (reset)
                data_ok |-> outstanding != 4'd0)
                else $error("data_ok with no request outstanding");

endmodule

bind icache_ctrl icache_ctrl_assert i_assert (
        .clk            (clk),
        .reset          (reset),
        .valid          (valid),
        .addr_ok        (addr_ok),
        .data_ok        (data_ok),
        .arvalid        (arvalid),
        .arready        (arready),
        .ar             (ar),
        .rready         (rready),
        .rvalid         (rvalid),
        .r              (r)
);

`default_nettype wire

// ==== tb_icache.sv ====
`default_nettype none

module tb_icache;
        import cache_pkg::*;
        import axi_pkg::*;

        typedef struct packed {
                logic [31:0]    addr;
                logic           cacheable;
                logic [3:0]     exp_ar;
        } row_t;

        localparam int row_count = 20;

        logic           clk;
        logic           reset;
        logic           valid;
        cpu_req_t       req;
        logic           addr_ok;
        logic           data_ok;
        word_t          rdata;
        axi_ar_t        ar;
        logic           arvalid;
        logic           arready;
        axi_r_t         r;
        logic           rvalid;
        logic           rready;

        row_t           table_rows [row_count];
        axi_ar_t        ar_log [$];
        logic [15:0]    lfsr_state = 16'd45251;
        logic           reset_done = 1'b0;
        int             ar_count = 0;
        int             resp_count = 0;
        int             accepted_count = 0;
        int             word_errors = 0;
        int             ar_errors = 0;
        int             count_errors = 0;
        int             flag_errors = 0;
        int             other_errors = 0;

        icache_top #(
                .index_width    (4)
        ) i_dut (
                .clk            (clk),
                .reset          (reset),
                .valid          (valid),
                .req            (req),
                .addr_ok        (addr_ok),
                .data_ok        (data_ok),
                .rdata          (rdata),
                .ar             (ar),
                .arvalid        (arvalid),
                .arready        (arready),
                .r              (r),
                .rvalid         (rvalid),
                .rready         (rready)
        );

        initial begin
                clk = 1'b0;
                forever begin
                        #4 clk = ~clk;
                end
        end

        // 16-bit fibonacci lfsr, taps 16 14 13 11
        function automatic logic take_bit();
                lfsr_state = {lfsr_state[14:0],
                              lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10]};
                return lfsr_state[0];
        endfunction

        // whole line for cacheable rows, the single word otherwise
        function automatic axi_ar_t expected_ar(input row_t row);
                axi_ar_t a;
                a.id = ar_id;
                a.size = size_word;
                a.burst = burst_incr;
                if (row.cacheable) begin
                        a.addr = row.addr & 32'hffff_fff0;
                        a.len = 8'd3;
                end else begin
                        a.addr = row.addr & 32'hffff_fffc;
                        a.len = 8'd0;
                end
                return a;
        endfunction

        task automatic check_word(input string name, input word_t exp, input word_t act);
                if (act !== exp) begin
                        word_errors++;
                        $display("** Error at %0t: %s expected %08h, actual %08h",
                                 $time, name, exp, act);
                end
        endtask

        task automatic check_ar(input string name, input axi_ar_t exp, input axi_ar_t act);
                if (act !== exp) begin
                        ar_errors++;
                        $display("** Error at %0t: %s expected %h, actual %h",
                                 $time, name, exp, act);
                end
        endtask

        task automatic check_count(input string name, input int exp, input int act);
                if (act != exp) begin
                        count_errors++;
                        $display("** Error at %0t: %s expected %0d, actual %0d",
                                 $time, name, exp, act);
                end
        endtask

        task automatic check_flag(input string name, input logic exp, input logic act);
                if (act !== exp) begin
                        flag_errors++;
                        $display("** Error at %0t: %s expected %b, actual %b",
                                 $time, name, exp, act);
                end
        endtask

        task automatic print_counts;
                $display("errors: word %0d, ar %0d, count %0d, flag %0d, other %0d",
                         word_errors, ar_errors, count_errors, flag_errors, other_errors);
        endtask

        // set = addr[7:4], tag = addr[31:8] with a 4-bit index
        task automatic load_table;
                table_rows[0] = '{32'h0000_1000, 1'b1, 4'd1};
                table_rows[1] = '{32'h0000_1004, 1'b1, 4'd0};
                table_rows[2] = '{32'h0000_1008, 1'b1, 4'd0};
                table_rows[3] = '{32'h0000_100c, 1'b1, 4'd0};
                table_rows[4] = '{32'h0000_1000, 1'b1, 4'd0};
                table_rows[5] = '{32'h0000_2014, 1'b1, 4'd1};
                table_rows[6] = '{32'h0000_2010, 1'b1, 4'd0};
                // same set as 0x1000, evicts it
                table_rows[7] = '{32'h0000_3004, 1'b1, 4'd1};
                table_rows[8] = '{32'h0000_3008, 1'b1, 4'd0};
                table_rows[9] = '{32'h0000_1004, 1'b1, 4'd1};
                table_rows[10] = '{32'h0000_100c, 1'b1, 4'd0};
                table_rows[11] = '{32'h0000_4028, 1'b0, 4'd1};
                table_rows[12] = '{32'h0000_4028, 1'b1, 4'd1};
                table_rows[13] = '{32'h0000_402c, 1'b1, 4'd0};
                table_rows[14] = '{32'h0000_1008, 1'b0, 4'd1};
                table_rows[15] = '{32'h0000_1000, 1'b1, 4'd0};
                table_rows[16] = '{32'h0000_2018, 1'b1, 4'd0};
                // last word of the line, it arrives on the final beat
                table_rows[17] = '{32'hffff_fffc, 1'b1, 4'd1};
                table_rows[18] = '{32'hffff_fff0, 1'b1, 4'd0};
                table_rows[19] = '{32'h0000_2010, 1'b1, 4'd0};
        endtask

        // misses wait for the cache to drain, hits go back to back
        task automatic run_table;
                int i;
                logic taken;
                i = 0;
                @(posedge clk);
                #1;
                while (i < row_count) begin
                        if (table_rows[i].exp_ar != 0 && resp_count != i) begin
                                valid = 1'b0;
                                @(posedge clk);
                                #1;
                        end else begin
                                valid = 1'b1;
                                req.addr = table_rows[i].addr;
                                req.cacheable = table_rows[i].cacheable;
                                @(negedge clk);
                                taken = addr_ok;
                                @(posedge clk);
                                #1;
                                if (taken) begin
                                        i++;
                                end
                        end
                end
                valid = 1'b0;
                req = '0;
                while (resp_count < row_count) begin
                        @(posedge clk);
                end
        endtask

        // bus memory: word at A reads as ~A
        initial begin
                logic a_bit;
                logic r_bit;
                logic busy;
                logic [31:0] cur_addr;
                int beats_left;
                arready = 1'b0;
                rvalid = 1'b0;
                r = '0;
                busy = 1'b0;
                cur_addr = '0;
                beats_left = 0;
                wait (reset_done);
                forever begin
                        @(posedge clk);
                        #1;
                        a_bit = take_bit();
                        r_bit = take_bit();
                        arready = !busy && a_bit;
                        rvalid = busy && r_bit;
                        r.id = ar_id;
                        r.data = ~cur_addr;
                        r.resp = 2'b00;
                        r.last = (beats_left == 1);
                        @(negedge clk);
                        if (arvalid && arready) begin
                                ar_count++;
                                ar_log.push_back(ar);
                                busy = 1'b1;
                                cur_addr = ar.addr;
                                beats_left = int'(ar.len) + 1;
                        end
                        if (rvalid && rready) begin
                                beats_left--;
                                cur_addr = cur_addr + 32'd4;
                                if (beats_left == 0) begin
                                        busy = 1'b0;
                                end
                        end
                end
        end

        // responses in order, each claiming the ar requests logged since the one before
        initial begin
                row_t row;
                axi_ar_t got;
                wait (reset_done);
                forever begin
                        @(negedge clk);
                        if (data_ok) begin
                                if (resp_count >= accepted_count) begin
                                        other_errors++;
                                        $display("data_ok at %0t with no request outstanding",
                                                 $time);
                                end else begin
                                        row = table_rows[resp_count];
                                        check_word("rdata", ~{row.addr[31:2], 2'b00}, rdata);
                                        check_count("ar handshakes of row", int'(row.exp_ar),
                                                    ar_log.size());
                                        while (ar_log.size() > 0) begin
                                                got = ar_log.pop_front();
                                                check_ar("ar", expected_ar(row), got);
                                        end
                                        resp_count++;
                                end
                        end
                        if (valid && addr_ok) begin
                                accepted_count++;
                        end
                end
        end

        initial begin
                repeat (row_count * 200) @(posedge clk);
                other_errors++;
                $display("watchdog expired with %0d of %0d responses received",
                         resp_count, row_count);
                print_counts();
                $display("Test failed");
                $finish;
        end

        initial begin
                int expected_total;
                valid = 1'b0;
                req = '0;
                reset = 1'b1;
                load_table();
                repeat (4) @(posedge clk);
                #1;
                reset = 1'b0;
                @(negedge clk);
                check_flag("addr_ok", 1'b0, addr_ok);
                check_flag("data_ok", 1'b0, data_ok);
                check_flag("arvalid", 1'b0, arvalid);
                check_flag("rready", 1'b0, rready);
                reset_done = 1'b1;
                run_table();
                // catch any stray pulse
                repeat (4) @(posedge clk);
                expected_total = 0;
                for (int i = 0; i < row_count; i++) begin
                        expected_total += int'(table_rows[i].exp_ar);
                end
                check_count("total ar handshakes", expected_total, ar_count);
                print_counts();
                if (word_errors + ar_errors + count_errors + flag_errors + other_errors == 0) begin
                        $display("Test passed");
                end else begin
                        $display("Test failed");
                end
                $finish;
        end

endmodule

`default_nettype wire

// ==== filelist.f ====
cache_pkg.sv
axi_pkg.sv
refill_counter.sv
tag_array.sv
data_array.sv
icache_ctrl.sv
icache_top.sv
icache_ctrl_assert.sv
tb_icache.sv

// ==== run.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_icache -f filelist.f -o sim_icache \
        && ./obj_dir/sim_icache > sim.log 2>&1 \
        || { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -qx "Test passed" sim.log \
        && echo "simulation ok" \
        || { echo "simulation reported errors"; exit 1; }
